// File: hdl/udp_config.svh
`ifndef UDP_CONFIG_SVH
`define UDP_CONFIG_SVH

// **********************************************************
// UDP layer build constants
// **********************************************************

// Fixed size of the UDP header on the wire.
// It holds the source port, destination port, length and checksum.
`define UDP_HDR_LEN 8

// Address width of the transmit payload FIFO.
// The largest payload the user can send is one FIFO's worth of bytes.
`define UDP_FIFO_AW 8

// Depth in bytes that follows from the address width.
`define UDP_FIFO_DEPTH (1 << `UDP_FIFO_AW)

`endif

// File: hdl/udp_hdr_pkg.sv
// **********************************************************
// Protocol field types
// **********************************************************

package udp_hdr_pkg;

  // One byte of any stream in the stack.
  typedef logic [7:0] byte_t;

  // Source or destination port of a UDP header.
  typedef logic [15:0] port_t;

  // UDP length field, header and payload together.
  // The IPv4 payload length uses the same width.
  typedef logic [15:0] udp_len_t;

  // UDP checksum field. Sent as zero and not checked on receive.
  typedef logic [15:0] chsum_t;

  // IPv4 address as it travels beside the byte streams.
  typedef logic [31:0] ipv4_addr_t;

endpackage

// File: hdl/udp_ctl_pkg.sv
`include "udp_config.svh"

// **********************************************************
// Control types
// **********************************************************

package udp_ctl_pkg;

  // Receive parser states.
  typedef enum logic [1:0] {rx_idle, rx_header, rx_payload, rx_drop} rx_state_t;

  // Transmit framer states.
  typedef enum logic [1:0] {tx_idle, tx_header, tx_payload} tx_state_t;

  // Fill count of the payload FIFO, wide enough to hold a full FIFO.
  typedef logic [`UDP_FIFO_AW:0] fifo_cnt_t;

endpackage

// File: hdl/udp_rx_parser.sv
`timescale 1ns/1ps
`include "udp_config.svh"

module udp_rx_parser (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  udp_hdr_pkg::port_t      local_port,
  input  udp_hdr_pkg::byte_t      rx_d,
  input  logic                    rx_v,
  input  logic                    rx_sof,
  input  logic                    rx_eof,
  input  logic                    rx_err,
  input  udp_hdr_pkg::ipv4_addr_t rx_src_ip,
  input  udp_hdr_pkg::udp_len_t   rx_ip_len,
  output udp_hdr_pkg::byte_t      up_d,
  output logic                    up_v,
  output logic                    up_sof,
  output logic                    up_eof,
  output logic                    up_err,
  output udp_hdr_pkg::ipv4_addr_t up_src_ip,
  output udp_hdr_pkg::port_t      up_src_port,
  output udp_hdr_pkg::udp_len_t   up_len
);

  localparam udp_hdr_pkg::udp_len_t HDR_LEN = `UDP_HDR_LEN;

  udp_ctl_pkg::rx_state_t state;
  udp_hdr_pkg::udp_len_t  byte_cnt;
  udp_hdr_pkg::udp_len_t  rcv_cnt;
  udp_hdr_pkg::udp_len_t  udp_len_q;
  logic                   err_seen;

  // Source port, destination port and length. The two checksum bytes are
  // never stored since the checksum is not verified.
  logic [47:0]            hdr_sr;
  udp_hdr_pkg::port_t     hdr_dst_port;
  udp_hdr_pkg::udp_len_t  hdr_len;
  logic                   hdr_last;
  logic                   accept;
  logic                   len_bad;

  assign hdr_dst_port = hdr_sr[31:16];
  assign hdr_len      = hdr_sr[15:0];
  assign rcv_cnt      = byte_cnt + 16'd1;

  // The eighth header byte is on rx_d right now, so the decision has to be
  // taken from the stored fields without waiting a cycle.
  assign hdr_last = rx_v && (state == udp_ctl_pkg::rx_header) && (byte_cnt == HDR_LEN - 16'd1);
  assign accept   = (hdr_dst_port == local_port) && (hdr_len > HDR_LEN) && !rx_eof;
  assign len_bad  = (rcv_cnt != udp_len_q) || (rcv_cnt != rx_ip_len);

  // **********************************************************
  // Packet state machine
  // **********************************************************

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= udp_ctl_pkg::rx_idle;
      byte_cnt <= '0;
      err_seen <= 1'b0;
    end else if (rx_v) begin
      byte_cnt <= rx_sof ? 16'd1 : rcv_cnt;
      err_seen <= rx_sof ? rx_err : (err_seen | rx_err);
      case (state)
        udp_ctl_pkg::rx_idle: begin
          if (rx_sof && !rx_eof) state <= udp_ctl_pkg::rx_header;
        end
        udp_ctl_pkg::rx_header: begin
          if (rx_eof) state <= udp_ctl_pkg::rx_idle;
          else if (hdr_last) state <= accept ? udp_ctl_pkg::rx_payload : udp_ctl_pkg::rx_drop;
        end
        udp_ctl_pkg::rx_payload, udp_ctl_pkg::rx_drop: begin
          if (rx_eof) state <= udp_ctl_pkg::rx_idle;
        end
        default: state <= udp_ctl_pkg::rx_idle;
      endcase
    end
  end

  // Header capture and side fields for the user.
  always_ff @(posedge clk) begin
    if (rx_v && ((state == udp_ctl_pkg::rx_idle && rx_sof) ||
                 (state == udp_ctl_pkg::rx_header && byte_cnt < HDR_LEN - 16'd2))) begin
      hdr_sr <= {hdr_sr[39:0], rx_d};
    end
    if (hdr_last && accept) begin
      up_src_ip   <= rx_src_ip;
      up_src_port <= hdr_sr[47:32];
      up_len      <= hdr_len - HDR_LEN;
      udp_len_q   <= hdr_len;
    end
  end

  // **********************************************************
  // User output
  // **********************************************************

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      up_v   <= 1'b0;
      up_sof <= 1'b0;
      up_eof <= 1'b0;
      up_err <= 1'b0;
    end else begin
      up_v   <= 1'b0;
      up_sof <= 1'b0;
      up_eof <= 1'b0;
      up_err <= 1'b0;
      if (rx_v && state == udp_ctl_pkg::rx_payload) begin
        up_v   <= 1'b1;
        up_sof <= (byte_cnt == HDR_LEN);
        up_eof <= rx_eof;
        up_err <= rx_eof && (len_bad || err_seen || rx_err);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_v && state == udp_ctl_pkg::rx_payload) up_d <= rx_d;
  end

endmodule

// File: hdl/udp_payload_fifo.sv
`timescale 1ns/1ps
`include "udp_config.svh"

module udp_payload_fifo #(
  parameter int AW = `UDP_FIFO_AW
) (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  udp_hdr_pkg::byte_t     wr_d,
  input  logic                   wr,
  input  logic                   rd,
  output udp_hdr_pkg::byte_t     rd_d,
  output logic                   empty,
  output udp_ctl_pkg::fifo_cnt_t count
);

  localparam int DEPTH = 1 << AW;

  udp_hdr_pkg::byte_t mem [DEPTH];

  // The extra pointer bit tells a full buffer from an empty one.
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign count = udp_ctl_pkg::fifo_cnt_t'(wr_ptr - rd_ptr);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr && !full) wr_ptr <= wr_ptr + 1'b1;
      if (rd && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr && !full) mem[wr_ptr[AW-1:0]] <= wr_d;
  end

  // Registered read port. rd_d keeps its byte until the next read.
  always_ff @(posedge clk) begin
    if (rd && !empty) rd_d <= mem[rd_ptr[AW-1:0]];
  end

endmodule

// File: hdl/udp_tx_framer.sv
`timescale 1ns/1ps
`include "udp_config.svh"

module udp_tx_framer (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  udp_hdr_pkg::port_t      local_port,
  input  logic                    dn_sof,
  input  logic                    dn_eof,
  input  udp_hdr_pkg::ipv4_addr_t dn_dst_ip,
  input  udp_hdr_pkg::port_t      dn_dst_port,
  output logic                    dn_busy,
  input  logic                    fifo_empty,
  input  udp_ctl_pkg::fifo_cnt_t  fifo_count,
  output logic                    fifo_rd,
  input  udp_hdr_pkg::byte_t      fifo_d,
  output udp_hdr_pkg::byte_t      tx_d,
  output logic                    tx_v,
  output logic                    tx_sof,
  output logic                    tx_eof,
  input  logic                    tx_ready,
  output udp_hdr_pkg::ipv4_addr_t tx_dst_ip,
  output udp_hdr_pkg::udp_len_t   tx_len
);

  localparam udp_hdr_pkg::udp_len_t HDR_LEN  = `UDP_HDR_LEN;
  localparam logic [2:0]            HDR_LAST = 3'(`UDP_HDR_LEN - 1);
  localparam udp_hdr_pkg::chsum_t   TX_CHSUM = '0;

  udp_ctl_pkg::tx_state_t    state;
  logic [2:0]                hdr_idx;
  udp_hdr_pkg::port_t        dst_port_q;
  logic [8*`UDP_HDR_LEN-1:0] hdr_word;
  udp_hdr_pkg::byte_t        hdr_byte;
  logic                      out_free;
  logic                      hdr_load;
  logic                      pl_load;
  logic                      eof_done;

  // The output register may take a new byte when it is empty or its byte
  // is being accepted in this cycle.
  assign out_free = !tx_v || tx_ready;
  assign hdr_load = out_free && (state == udp_ctl_pkg::tx_header);
  assign pl_load  = out_free && (state == udp_ctl_pkg::tx_payload) && !tx_eof;
  assign eof_done = tx_v && tx_ready && tx_eof;

  // Most significant byte of each field goes first.
  assign hdr_word = {local_port, dst_port_q, tx_len, TX_CHSUM};
  assign hdr_byte = hdr_word[8*(HDR_LAST - hdr_idx) +: 8];

  // While in payload with tx_eof low there is always one unsent byte on
  // fifo_d, so the next read is issued exactly when that byte is loaded.
  assign fifo_rd = (hdr_load && hdr_idx == HDR_LAST) || (pl_load && !fifo_empty);

  // **********************************************************
  // Frame sequencing
  // **********************************************************

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= udp_ctl_pkg::tx_idle;
      hdr_idx <= '0;
      dn_busy <= 1'b0;
    end else begin
      if (dn_sof) dn_busy <= 1'b1;
      else if (eof_done) dn_busy <= 1'b0;
      case (state)
        udp_ctl_pkg::tx_idle: begin
          if (dn_eof) begin
            state   <= udp_ctl_pkg::tx_header;
            hdr_idx <= '0;
          end
        end
        udp_ctl_pkg::tx_header: begin
          if (out_free) begin
            hdr_idx <= hdr_idx + 3'd1;
            if (hdr_idx == HDR_LAST) state <= udp_ctl_pkg::tx_payload;
          end
        end
        udp_ctl_pkg::tx_payload: begin
          if (eof_done) state <= udp_ctl_pkg::tx_idle;
        end
        default: state <= udp_ctl_pkg::tx_idle;
      endcase
    end
  end

  // The last payload byte lands in the FIFO one cycle after dn_eof, so the
  // length is taken while the first header byte goes out.
  always_ff @(posedge clk) begin
    if (dn_sof) begin
      tx_dst_ip  <= dn_dst_ip;
      dst_port_q <= dn_dst_port;
    end
    if (state == udp_ctl_pkg::tx_header && hdr_idx == 3'd0) begin
      tx_len <= udp_hdr_pkg::udp_len_t'(fifo_count) + HDR_LEN;
    end
  end

  // **********************************************************
  // Output register
  // **********************************************************

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_v   <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
    end else if (out_free) begin
      tx_v   <= hdr_load || pl_load;
      tx_sof <= hdr_load && (hdr_idx == 3'd0);
      tx_eof <= pl_load && fifo_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_load) tx_d <= hdr_byte;
    else if (pl_load) tx_d <= fifo_d;
  end

endmodule

// File: hdl/udp_layer.sv
`timescale 1ns/1ps

module udp_layer (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  udp_hdr_pkg::port_t      local_port,
  input  udp_hdr_pkg::byte_t      rx_d,
  input  logic                    rx_v,
  input  logic                    rx_sof,
  input  logic                    rx_eof,
  input  logic                    rx_err,
  input  udp_hdr_pkg::ipv4_addr_t rx_src_ip,
  input  udp_hdr_pkg::udp_len_t   rx_ip_len,
  output udp_hdr_pkg::byte_t      up_d,
  output logic                    up_v,
  output logic                    up_sof,
  output logic                    up_eof,
  output logic                    up_err,
  output udp_hdr_pkg::ipv4_addr_t up_src_ip,
  output udp_hdr_pkg::port_t      up_src_port,
  output udp_hdr_pkg::udp_len_t   up_len,
  input  udp_hdr_pkg::byte_t      dn_d,
  input  logic                    dn_v,
  input  logic                    dn_sof,
  input  logic                    dn_eof,
  input  udp_hdr_pkg::ipv4_addr_t dn_dst_ip,
  input  udp_hdr_pkg::port_t      dn_dst_port,
  output logic                    dn_busy,
  output udp_hdr_pkg::byte_t      tx_d,
  output logic                    tx_v,
  output logic                    tx_sof,
  output logic                    tx_eof,
  input  logic                    tx_ready,
  output udp_hdr_pkg::ipv4_addr_t tx_dst_ip,
  output udp_hdr_pkg::udp_len_t   tx_len
);

  logic                   fifo_rd;
  logic                   fifo_empty;
  udp_hdr_pkg::byte_t     fifo_d;
  udp_ctl_pkg::fifo_cnt_t fifo_count;

  udp_rx_parser udp_rx_parser_inst (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .local_port  (local_port),
    .rx_d        (rx_d),
    .rx_v        (rx_v),
    .rx_sof      (rx_sof),
    .rx_eof      (rx_eof),
    .rx_err      (rx_err),
    .rx_src_ip   (rx_src_ip),
    .rx_ip_len   (rx_ip_len),
    .up_d        (up_d),
    .up_v        (up_v),
    .up_sof      (up_sof),
    .up_eof      (up_eof),
    .up_err      (up_err),
    .up_src_ip   (up_src_ip),
    .up_src_port (up_src_port),
    .up_len      (up_len)
  );

  // The user payload is written straight into the FIFO.
  udp_payload_fifo udp_payload_fifo_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr_d    (dn_d),
    .wr      (dn_v),
    .rd      (fifo_rd),
    .rd_d    (fifo_d),
    .empty   (fifo_empty),
    .count   (fifo_count)
  );

  udp_tx_framer udp_tx_framer_inst (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .local_port  (local_port),
    .dn_sof      (dn_sof),
    .dn_eof      (dn_eof),
    .dn_dst_ip   (dn_dst_ip),
    .dn_dst_port (dn_dst_port),
    .dn_busy     (dn_busy),
    .fifo_empty  (fifo_empty),
    .fifo_count  (fifo_count),
    .fifo_rd     (fifo_rd),
    .fifo_d      (fifo_d),
    .tx_d        (tx_d),
    .tx_v        (tx_v),
    .tx_sof      (tx_sof),
    .tx_eof      (tx_eof),
    .tx_ready    (tx_ready),
    .tx_dst_ip   (tx_dst_ip),
    .tx_len      (tx_len)
  );

endmodule

// File: verif/udp_model.svh
`ifndef UDP_MODEL_SVH
`define UDP_MODEL_SVH

`include "udp_config.svh"

// **********************************************************
// Packet model
// **********************************************************

typedef logic [7:0] byte_q_t[$];

// An output byte with its side fields. Address in 79:48, port in 47:32, length in 31:16,
// then err, sof, eof and the data byte in the low bits.
typedef logic [79:0] word_t;
typedef word_t word_q_t[$];

function automatic word_t make_word(input logic [31:0] ip, input logic [15:0] port,
                                    input logic [15:0] len, input logic err, input logic sof,
                                    input logic eof, input logic [7:0] d);
  return {ip, port, len, 5'd0, err, sof, eof, d};
endfunction

// The checksum bytes are arbitrary since the receiver ignores them.
function automatic byte_q_t build_rx_packet(input logic [15:0] src_port,
                                            input logic [15:0] dst_port,
                                            input logic [15:0] len_field,
                                            input byte_q_t payload);
  byte_q_t pkt;
  pkt = '{src_port[15:8], src_port[7:0], dst_port[15:8], dst_port[7:0],
          len_field[15:8], len_field[7:0], 8'hc3, 8'h5a};
  foreach (payload[i]) pkt.push_back(payload[i]);
  return pkt;
endfunction

// Payload bytes the user should see. Another port or an empty payload gives nothing.
function automatic word_q_t predict_up(input byte_q_t pkt, input logic [15:0] local_port,
                                       input logic [31:0] src_ip, input int ip_len,
                                       input logic err_in);
  word_q_t q;
  int      len_field;
  int      n;
  logic    bad;
  n = pkt.size();
  len_field = {pkt[4], pkt[5]};
  if ({pkt[2], pkt[3]} != local_port || len_field <= `UDP_HDR_LEN || n <= `UDP_HDR_LEN) return q;
  bad = (n != len_field) || (n != ip_len) || err_in;
  for (int i = `UDP_HDR_LEN; i < n; i++) begin
    q.push_back(make_word(src_ip, {pkt[0], pkt[1]}, 16'(len_field - `UDP_HDR_LEN),
                          bad && i == n - 1, i == `UDP_HDR_LEN, i == n - 1, pkt[i]));
  end
  return q;
endfunction

// Header, then payload, as the IPv4 layer should accept it. The checksum is zero.
function automatic word_q_t frame_tx(input byte_q_t payload, input logic [15:0] local_port,
                                     input logic [15:0] dst_port, input logic [31:0] dst_ip);
  word_q_t     q;
  byte_q_t     frame;
  logic [15:0] len;
  len = 16'(payload.size() + `UDP_HDR_LEN);
  frame = '{local_port[15:8], local_port[7:0], dst_port[15:8], dst_port[7:0],
            len[15:8], len[7:0], 8'h00, 8'h00};
  foreach (payload[i]) frame.push_back(payload[i]);
  foreach (frame[i]) begin
    q.push_back(make_word(dst_ip, 16'h0000, len, 1'b0, i == 0, i == frame.size() - 1, frame[i]));
  end
  return q;
endfunction

`endif

// File: verif/udp_layer_tb.sv
`timescale 1ns/1ps
`include "udp_config.svh"

module udp_layer_tb;

  `include "udp_model.svh"

  localparam int N_FILTER  = 30;
  localparam int N_LEN_ERR = 8;
  localparam int N_TX      = 6;
  localparam int N_BP      = 6;
  localparam int N_CONC    = 4;
  localparam int PKT_TOTAL = N_FILTER + N_LEN_ERR + N_TX + N_BP + 3 * N_CONC;
  localparam int MAX_PKT   = `UDP_HDR_LEN + `UDP_FIFO_DEPTH;
  localparam int WATCHDOG_CYCLES = PKT_TOTAL * MAX_PKT * 4 + 2000;
  localparam logic [15:0] LOCAL_PORT = 16'h04d2;

  logic                    clk;
  logic                    fsm_rst;
  udp_hdr_pkg::port_t      local_port;
  udp_hdr_pkg::byte_t      rx_d;
  logic                    rx_v, rx_sof, rx_eof, rx_err;
  udp_hdr_pkg::ipv4_addr_t rx_src_ip;
  udp_hdr_pkg::udp_len_t   rx_ip_len;
  udp_hdr_pkg::byte_t      up_d;
  logic                    up_v, up_sof, up_eof, up_err;
  udp_hdr_pkg::ipv4_addr_t up_src_ip;
  udp_hdr_pkg::port_t      up_src_port;
  udp_hdr_pkg::udp_len_t   up_len;
  udp_hdr_pkg::byte_t      dn_d;
  logic                    dn_v, dn_sof, dn_eof, dn_busy;
  udp_hdr_pkg::ipv4_addr_t dn_dst_ip;
  udp_hdr_pkg::port_t      dn_dst_port;
  udp_hdr_pkg::byte_t      tx_d;
  logic                    tx_v, tx_sof, tx_eof, tx_ready;
  udp_hdr_pkg::ipv4_addr_t tx_dst_ip;
  udp_hdr_pkg::udp_len_t   tx_len;

  integer      seed = 32'h47fc;
  int          errors = 0;
  string       test_name = "reset";
  logic        bp_mode = 1'b0;
  logic        tx_stall = 1'b0;
  logic [10:0] tx_held;
  word_q_t     exp_up_q;
  word_q_t     exp_tx_q;
  word_t       up_word;
  word_t       tx_word;

  udp_layer udp_layer_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string what, input logic [79:0] expected, input logic [79:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("error in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // **********************************************************
  // Stimulus
  // **********************************************************

  task automatic drive_rx(input byte_q_t pkt, input logic [31:0] ip, input int err_pos);
    for (int i = 0; i < pkt.size(); i++) begin
      @(negedge clk);
      // An idle cycle now and then inside the packet.
      if (i > 0 && $random(seed) % 4 == 0) begin
        rx_v = 1'b0;
        @(negedge clk);
      end
      rx_v      = 1'b1;
      rx_d      = pkt[i];
      rx_sof    = (i == 0);
      rx_eof    = (i == pkt.size() - 1);
      rx_err    = (i == err_pos);
      rx_src_ip = ip;
      rx_ip_len = 16'(pkt.size());
    end
    @(negedge clk);
    {rx_v, rx_sof, rx_eof, rx_err} = 4'b0000;
  endtask

  // Mode 0 is a clean packet to either port, 1 a wrong length field, 2 an rx_err.
  task automatic random_rx(input int mode);
    byte_q_t     payload;
    byte_q_t     pkt;
    logic [15:0] dst;
    logic [15:0] len_field;
    logic [31:0] ip;
    int          n;
    int          err_pos;
    n = $unsigned($random(seed)) % 41;
    if (mode != 0 && n == 0) n = 1;
    repeat (n) payload.push_back(8'($random(seed)));
    if (mode != 0 || $random(seed) % 2 == 0) dst = LOCAL_PORT;
    else dst = LOCAL_PORT + 16'd1 + 16'($unsigned($random(seed)) % 256);
    len_field = 16'(n + `UDP_HDR_LEN);
    if (mode == 1) len_field = len_field + 16'd1 + 16'($unsigned($random(seed)) % 4);
    err_pos = (mode == 2) ? $unsigned($random(seed)) % (n + `UDP_HDR_LEN) : -1;
    ip = $random(seed);
    pkt = build_rx_packet(16'($random(seed)), dst, len_field, payload);
    exp_up_q = {exp_up_q, predict_up(pkt, LOCAL_PORT, ip, pkt.size(), err_pos >= 0)};
    drive_rx(pkt, ip, err_pos);
  endtask

  task automatic transmit_payload(input int n);
    byte_q_t     payload;
    logic [31:0] ip;
    logic [15:0] port;
    repeat (n) payload.push_back(8'($random(seed)));
    ip = $random(seed);
    port = 16'($random(seed));
    while (dn_busy) @(negedge clk);
    exp_tx_q = {exp_tx_q, frame_tx(payload, LOCAL_PORT, port, ip)};
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if (i == 1) check("dn_busy after start", 1, dn_busy);
      dn_v        = 1'b1;
      dn_d        = payload[i];
      dn_sof      = (i == 0);
      dn_eof      = (i == n - 1);
      dn_dst_ip   = ip;
      dn_dst_port = port;
    end
    @(negedge clk);
    if (n == 1) check("dn_busy after start", 1, dn_busy);
    {dn_v, dn_sof, dn_eof} = 3'b000;
    while (exp_tx_q.size() != 0) @(negedge clk);
    check("dn_busy after frame", 0, dn_busy);
  endtask

  task automatic drain_receive();
    while (exp_up_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  always @(negedge clk) begin
    tx_ready = bp_mode ? 1'($random(seed)) : 1'b1;
  end

  // **********************************************************
  // Monitors
  // **********************************************************

  always @(posedge clk) begin
    if (!fsm_rst) begin
      if (up_v) begin
        up_word = make_word(up_src_ip, up_src_port, up_len, up_err, up_sof, up_eof, up_d);
        if (exp_up_q.size() == 0) begin
          errors++;
          $display("unexpected byte on the user receive output in %s", test_name);
        end else begin
          check("receive byte", exp_up_q.pop_front(), up_word);
        end
      end else if (up_err) begin
        errors++;
        $display("up_err pulsed without a payload byte in %s", test_name);
      end
    end
  end

  always @(posedge clk) begin
    if (!fsm_rst) begin
      if (tx_stall) check("held output", tx_held, {tx_v, tx_sof, tx_eof, tx_d});
      if (tx_v && !dn_busy) begin
        errors++;
        $display("tx_v is high while dn_busy is low in %s", test_name);
      end
      if (tx_v && tx_ready) begin
        tx_word = make_word(tx_dst_ip, 16'h0000, tx_len, 1'b0, tx_sof, tx_eof, tx_d);
        if (exp_tx_q.size() == 0) begin
          errors++;
          $display("unexpected byte accepted on the transmit output in %s", test_name);
        end else begin
          check("transmit byte", exp_tx_q.pop_front(), tx_word);
        end
      end
      tx_stall = tx_v && !tx_ready;
      tx_held  = {tx_v, tx_sof, tx_eof, tx_d};
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // **********************************************************
  // Test sequence
  // **********************************************************

  initial begin
    fsm_rst    = 1'b1;
    local_port = LOCAL_PORT;
    {rx_d, rx_v, rx_sof, rx_eof, rx_err, rx_src_ip, rx_ip_len} = '0;
    {dn_d, dn_v, dn_sof, dn_eof, dn_dst_ip, dn_dst_port} = '0;
    tx_ready = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    @(negedge clk);
    check("control outputs", 0, {up_v, up_sof, up_eof, up_err, tx_v, tx_sof, tx_eof, dn_busy});

    test_name = "port filter";
    repeat (N_FILTER) random_rx(0);
    test_name = "length error";
    for (int i = 0; i < N_LEN_ERR; i++) random_rx(1 + i % 2);
    drain_receive();

    test_name = "transmit";
    transmit_payload(1);
    transmit_payload(`UDP_FIFO_DEPTH);
    repeat (N_TX - 2) transmit_payload(1 + $unsigned($random(seed)) % `UDP_FIFO_DEPTH);

    test_name = "back-pressure";
    bp_mode = 1'b1;
    repeat (N_BP) transmit_payload(1 + $unsigned($random(seed)) % `UDP_FIFO_DEPTH);

    test_name = "concurrent";
    fork
      repeat (N_CONC) transmit_payload(1 + $unsigned($random(seed)) % `UDP_FIFO_DEPTH);
      repeat (2 * N_CONC) random_rx(0);
    join
    drain_receive();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+hdl
+incdir+verif
hdl/udp_hdr_pkg.sv
hdl/udp_ctl_pkg.sv
hdl/udp_rx_parser.sv
hdl/udp_payload_fifo.sv
hdl/udp_tx_framer.sv
hdl/udp_layer.sv
verif/udp_layer_tb.sv

// File: Makefile
# Verilator simulation of the UDP layer.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= udp_layer_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

PASS_MSG := *** TEST PASSED ***
SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv verif/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
